/* hdl/mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] instr_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	// operand source for the forwarding muxes.
	typedef enum logic [1:0] {
		fwd_orig,
		fwd_from_m,
		fwd_from_w
	} fwd_sel_t;

	// link is pc plus 8, kept for jal.
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link
	} wb_sel_t;

	typedef enum logic [1:0] {
		npc_seq,
		npc_beq,
		npc_bne,
		npc_jump
	} npc_mode_t;

	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// stores keep rt in dest with reg_write low.
	typedef struct packed {
		alu_op_t   alu_op;
		logic      alu_src_imm;
		logic      mem_write;
		logic      reg_write;
		wb_sel_t   wb_sel;
		reg_addr_t dest;
	} ex_ctrl_t;

	localparam ex_ctrl_t ctrl_bubble = '{
		alu_op:      alu_add,
		alu_src_imm: 1'b0,
		mem_write:   1'b0,
		reg_write:   1'b0,
		wb_sel:      wb_alu,
		dest:        5'd0
	};

	typedef struct packed {
		word_t     pc;
		reg_addr_t dest;
		word_t     data;
	} retire_t;

	typedef struct packed {
		word_t  pc;
		instr_t instr;
	} d_stage_t;

	typedef struct packed {
		word_t pc;
		word_t op1;
		word_t op2;
		word_t imm;
	} e_stage_t;

	typedef struct packed {
		word_t pc;
		word_t alu_y;
		word_t store_data;
	} m_stage_t;

	typedef struct packed {
		word_t pc;
		word_t alu_y;
		word_t mem_data;
	} w_stage_t;

endpackage

/* hdl/npc_unit.sv */
`timescale 1ns/1ps

module npc_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  mips_pkg::npc_mode_t npc_mode,
	input  mips_pkg::word_t   d_pc,
	input  mips_pkg::word_t   op1,
	input  mips_pkg::word_t   op2,
	input  logic [15:0]       imm16,
	input  logic [25:0]       target,
	output mips_pkg::word_t   pc
);
	import mips_pkg::*;

	word_t pc_plus4;
	word_t d_pc_plus4;
	word_t br_target;
	word_t j_target;
	word_t next_pc;
	logic  equal;

	assign pc_plus4   = pc + 32'd4;
	assign d_pc_plus4 = d_pc + 32'd4;
	// branch offset is relative to the delay slot.
	assign br_target  = d_pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
	assign j_target   = {d_pc_plus4[31:28], target, 2'b00};
	assign equal      = (op1 == op2);

	always_comb begin
		case (npc_mode)
			npc_beq:  next_pc = equal ? br_target : pc_plus4;
			npc_bne:  next_pc = equal ? pc_plus4 : br_target;
			npc_jump: next_pc = j_target;
			default:  next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= next_pc;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("fetch pc %h not word aligned", pc);

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t raddr1,
	input  mips_pkg::reg_addr_t raddr2,
	output mips_pkg::word_t     rdata1,
	output mips_pkg::word_t     rdata2,
	input  logic                we,
	input  mips_pkg::reg_addr_t waddr,
	input  mips_pkg::word_t     wdata
);
	import mips_pkg::*;

	// r0 has no storage.
	word_t regs [1:31];

	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		// a write in this cycle reaches decode directly.
		if (we && waddr == addr) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  mips_pkg::alu_op_t op,
	output mips_pkg::word_t   y
);
	import mips_pkg::*;

	word_t sum;
	word_t diff;
	logic  less;

	assign sum  = a + b;
	assign diff = a - b;
	// signed compare.
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: begin
				y = sum;
			end
			alu_sub: begin
				y = diff;
			end
			alu_and: begin
				y = a & b;
			end
			alu_or: begin
				y = a | b;
			end
			alu_slt: begin
				y = {31'd0, less};
			end
			alu_lui: begin
				y = {b[15:0], 16'h0000};
			end
			default: begin
				y = sum;
			end
		endcase
	end

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
	parameter int DM_WORDS = 256
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            we,
	input  mips_pkg::word_t addr,
	input  mips_pkg::word_t wdata,
	output mips_pkg::word_t rdata
);
	import mips_pkg::*;

	localparam int aw = $clog2(DM_WORDS);

	word_t          mem [DM_WORDS];
	logic [aw-1:0]  index;

	// byte offset dropped, upper bits wrap.
	assign index = addr[aw+1:2];
	assign rdata = mem[index];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[index] <= wdata;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) we |-> addr[1:0] == 2'b00)
		else $error("store address %h not word aligned", addr);

endmodule

/* hdl/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control (
	input  mips_pkg::instr_t    d_instr,
	input  mips_pkg::ex_ctrl_t  e_ctrl,
	input  logic                e_is_load,
	input  mips_pkg::ex_ctrl_t  m_ctrl,
	input  logic                m_is_load,
	input  mips_pkg::ex_ctrl_t  w_ctrl,
	output logic                stall,
	output mips_pkg::npc_mode_t npc_mode,
	output mips_pkg::reg_addr_t raddr1,
	output mips_pkg::reg_addr_t raddr2,
	output mips_pkg::fwd_sel_t  fwd_d1,
	output mips_pkg::fwd_sel_t  fwd_d2,
	output mips_pkg::fwd_sel_t  fwd_e1,
	output mips_pkg::fwd_sel_t  fwd_e2,
	output mips_pkg::fwd_sel_t  fwd_m,
	output mips_pkg::ex_ctrl_t  d_ctrl
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	logic       uses_rs;
	logic       uses_rt;
	logic       is_branch;
	logic       load_use;
	logic       branch_wait;

	function automatic logic hits(reg_addr_t src, logic used, ex_ctrl_t c);
		return used && src != '0 && c.reg_write && src == c.dest;
	endfunction

	// select for an operand read in decode this cycle.
	function automatic fwd_sel_t fwd_now(reg_addr_t src, logic used);
		if (hits(src, used, m_ctrl) && !m_is_load) begin
			return fwd_from_m;
		end
		if (hits(src, used, w_ctrl)) begin
			return fwd_from_w;
		end
		return fwd_orig;
	endfunction

	// select for the same operand one cycle later in execute.
	function automatic fwd_sel_t fwd_next(reg_addr_t src, logic used);
		if (hits(src, used, e_ctrl)) begin
			return fwd_from_m;
		end
		if (hits(src, used, m_ctrl)) begin
			return fwd_from_w;
		end
		return fwd_orig;
	endfunction

	assign opcode = d_instr[31:26];
	assign rs     = d_instr[25:21];
	assign rt     = d_instr[20:16];
	assign rd     = d_instr[15:11];
	assign funct  = d_instr[5:0];
	assign raddr1 = rs;
	assign raddr2 = rt;

	always_comb begin
		d_ctrl   = ctrl_bubble;
		npc_mode = npc_seq;
		uses_rs  = 1'b0;
		uses_rt  = 1'b0;
		case (opcode)
			op_rtype: begin
				uses_rs          = 1'b1;
				uses_rt          = 1'b1;
				d_ctrl.reg_write = 1'b1;
				d_ctrl.dest      = rd;
				case (funct)
					fn_addu: d_ctrl.alu_op = alu_add;
					fn_subu: d_ctrl.alu_op = alu_sub;
					fn_and:  d_ctrl.alu_op = alu_and;
					fn_or:   d_ctrl.alu_op = alu_or;
					fn_slt:  d_ctrl.alu_op = alu_slt;
					default: begin
						d_ctrl  = ctrl_bubble;
						uses_rs = 1'b0;
						uses_rt = 1'b0;
					end
				endcase
			end
			op_addiu, op_ori, op_lui, op_lw: begin
				uses_rs            = (opcode != op_lui);
				d_ctrl.alu_src_imm = 1'b1;
				d_ctrl.reg_write   = 1'b1;
				d_ctrl.dest        = rt;
				if (opcode == op_ori) begin
					d_ctrl.alu_op = alu_or;
				end else if (opcode == op_lui) begin
					d_ctrl.alu_op = alu_lui;
				end
				if (opcode == op_lw) begin
					d_ctrl.wb_sel = wb_mem;
				end
			end
			op_sw: begin
				uses_rs            = 1'b1;
				uses_rt            = 1'b1;
				d_ctrl.alu_src_imm = 1'b1;
				d_ctrl.mem_write   = 1'b1;
				d_ctrl.dest        = rt;
			end
			op_beq, op_bne: begin
				uses_rs  = 1'b1;
				uses_rt  = 1'b1;
				npc_mode = (opcode == op_beq) ? npc_beq : npc_bne;
			end
			op_j: begin
				npc_mode = npc_jump;
			end
			default: begin
				d_ctrl = ctrl_bubble;
			end
		endcase
	end

	assign is_branch = (npc_mode == npc_beq) || (npc_mode == npc_bne);

	assign load_use = e_is_load &&
		(hits(rs, uses_rs, e_ctrl) || hits(rt, uses_rt, e_ctrl));

	// the comparator works in decode, so it waits for any result still in flight.
	assign branch_wait = is_branch &&
		(hits(rs, uses_rs, e_ctrl) || hits(rt, uses_rt, e_ctrl) ||
		(m_is_load && (hits(rs, uses_rs, m_ctrl) || hits(rt, uses_rt, m_ctrl))));

	assign stall = load_use || branch_wait;

	always_comb begin
		fwd_d1 = fwd_now(rs, uses_rs);
		fwd_d2 = fwd_now(rt, uses_rt);
		fwd_e1 = fwd_next(rs, uses_rs);
		fwd_e2 = fwd_next(rt, uses_rt);
	end

	// store data sees the writer now in execute once it reaches write-back.
	assign fwd_m  = (d_ctrl.mem_write && hits(rt, uses_rt, e_ctrl)) ? fwd_from_w : fwd_orig;

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/1ps

module mips_core #(
	parameter int DM_WORDS = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	output mips_pkg::word_t   imem_addr,
	input  mips_pkg::instr_t  imem_data,
	output logic              retire_valid,
	output mips_pkg::retire_t retire
);
	import mips_pkg::*;

	logic      stall;
	npc_mode_t npc_mode;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	fwd_sel_t  fwd_d1;
	fwd_sel_t  fwd_d2;
	fwd_sel_t  fwd_e1;
	fwd_sel_t  fwd_e2;
	fwd_sel_t  fwd_m;
	ex_ctrl_t  d_ctrl;

	word_t     pc;
	d_stage_t  d_q;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	word_t     d_op1;
	word_t     d_op2;
	word_t     d_imm;

	e_stage_t  e_q;
	ex_ctrl_t  e_ctrl;
	fwd_sel_t  e_fwd1;
	fwd_sel_t  e_fwd2;
	fwd_sel_t  e_fwd_m;
	logic      e_is_load;
	word_t     e_a;
	word_t     e_b_reg;
	word_t     e_b;
	word_t     e_alu_y;

	m_stage_t  m_q;
	ex_ctrl_t  m_ctrl;
	fwd_sel_t  m_fwd;
	logic      m_is_load;
	word_t     m_store_data;
	word_t     m_rdata;

	w_stage_t  w_q;
	ex_ctrl_t  w_ctrl;
	word_t     w_data;

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t orig, word_t from_m, word_t from_w);
		case (sel)
			fwd_from_m: return from_m;
			fwd_from_w: return from_w;
			default:    return orig;
		endcase
	endfunction

	pipe_control u_ctrl (
		.d_instr   (d_q.instr),
		.e_ctrl    (e_ctrl),
		.e_is_load (e_is_load),
		.m_ctrl    (m_ctrl),
		.m_is_load (m_is_load),
		.w_ctrl    (w_ctrl),
		.stall     (stall),
		.npc_mode  (npc_mode),
		.raddr1    (raddr1),
		.raddr2    (raddr2),
		.fwd_d1    (fwd_d1),
		.fwd_d2    (fwd_d2),
		.fwd_e1    (fwd_e1),
		.fwd_e2    (fwd_e2),
		.fwd_m     (fwd_m),
		.d_ctrl    (d_ctrl)
	);

	npc_unit u_npc (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.npc_mode (npc_mode),
		.d_pc     (d_q.pc),
		.op1      (d_op1),
		.op2      (d_op2),
		.imm16    (d_q.instr[15:0]),
		.target   (d_q.instr[25:0]),
		.pc       (pc)
	);

	assign imem_addr = pc;

	// decode register, instr resets to a nop.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_q <= '0;
		end else if (!stall) begin
			d_q <= '{pc: pc, instr: imem_data};
		end
	end

	reg_file u_rf (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.we     (w_ctrl.reg_write),
		.waddr  (w_ctrl.dest),
		.wdata  (w_data)
	);

	assign d_op1 = fwd_mux(fwd_d1, rf_rdata1, m_q.alu_y, w_data);
	assign d_op2 = fwd_mux(fwd_d2, rf_rdata2, m_q.alu_y, w_data);
	// ori zero extends, the rest sign extend.
	assign d_imm = (d_ctrl.alu_op == alu_or) ? {16'h0000, d_q.instr[15:0]} :
		{{16{d_q.instr[15]}}, d_q.instr[15:0]};

	always_ff @(posedge clk) begin
		e_q <= '{pc: d_q.pc, op1: d_op1, op2: d_op2, imm: d_imm};
		m_q <= '{pc: e_q.pc, alu_y: e_alu_y, store_data: e_b_reg};
		w_q <= '{pc: m_q.pc, alu_y: m_q.alu_y, mem_data: m_rdata};
	end

	// a stall sends a bubble into execute.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_ctrl  <= ctrl_bubble;
			e_fwd1  <= fwd_orig;
			e_fwd2  <= fwd_orig;
			e_fwd_m <= fwd_orig;
			m_ctrl  <= ctrl_bubble;
			m_fwd   <= fwd_orig;
			w_ctrl  <= ctrl_bubble;
		end else begin
			e_ctrl  <= stall ? ctrl_bubble : d_ctrl;
			e_fwd1  <= stall ? fwd_orig : fwd_e1;
			e_fwd2  <= stall ? fwd_orig : fwd_e2;
			e_fwd_m <= stall ? fwd_orig : fwd_m;
			m_ctrl  <= e_ctrl;
			m_fwd   <= e_fwd_m;
			w_ctrl  <= m_ctrl;
		end
	end

	assign e_is_load = (e_ctrl.wb_sel == wb_mem);
	assign m_is_load = (m_ctrl.wb_sel == wb_mem);

	assign e_a     = fwd_mux(e_fwd1, e_q.op1, m_q.alu_y, w_data);
	assign e_b_reg = fwd_mux(e_fwd2, e_q.op2, m_q.alu_y, w_data);
	assign e_b     = e_ctrl.alu_src_imm ? e_q.imm : e_b_reg;

	alu u_alu (
		.a  (e_a),
		.b  (e_b),
		.op (e_ctrl.alu_op),
		.y  (e_alu_y)
	);

	assign m_store_data = (m_fwd == fwd_from_w) ? w_data : m_q.store_data;

	data_mem #(
		.DM_WORDS (DM_WORDS)
	) u_dm (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (m_ctrl.mem_write),
		.addr  (m_q.alu_y),
		.wdata (m_store_data),
		.rdata (m_rdata)
	);

	always_comb begin
		case (w_ctrl.wb_sel)
			wb_mem:  w_data = w_q.mem_data;
			wb_link: w_data = w_q.pc + 32'd8;
			default: w_data = w_q.alu_y;
		endcase
	end

	assign retire_valid = w_ctrl.reg_write && (w_ctrl.dest != '0);
	assign retire       = '{pc: w_q.pc, dest: w_ctrl.dest, data: w_data};

	// only a branch behind a load waits a second cycle.
	assert property (@(posedge clk) disable iff (!rst_n)
		stall && $past(stall) |-> is_branch_mode(npc_mode) && !$past(stall, 2))
		else $error("stall held longer than the hazard needs");

	// execute-stage selects must find a writer where they point.
	assert property (@(posedge clk) disable iff (!rst_n)
		(e_fwd1 == fwd_from_m || e_fwd2 == fwd_from_m) |-> m_ctrl.reg_write && !m_is_load)
		else $error("forward from memory stage without a writer");

	assert property (@(posedge clk) disable iff (!rst_n)
		(e_fwd1 == fwd_from_w || e_fwd2 == fwd_from_w || m_fwd == fwd_from_w) |->
		w_ctrl.reg_write)
		else $error("forward from write-back stage without a writer");

	function automatic logic is_branch_mode(npc_mode_t mode);
		return (mode == npc_beq) || (mode == npc_bne);
	endfunction

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset spans three rising edges and lets go on a falling edge.
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* verification/tb_program.svh */
localparam int prog_words = 38;
localparam int test_count = 5;
localparam int exp_count  = 28;

instr_t  prog      [prog_words];
retire_t exp_rec   [exp_count];
int      exp_test  [exp_count];
string   test_name [test_count];
int      test_last [test_count];
int      fill_pos;
int      exp_pos;

function automatic instr_t rtype_word(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
		reg_addr_t rt);
	return {op_rtype, rs, rt, rd, 5'd0, fn};
endfunction

function automatic instr_t itype_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
		logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic instr_t jump_word(word_t dest_pc);
	return {op_j, dest_pc[27:2]};
endfunction

task automatic add_instr(instr_t w);
	prog[fill_pos] = w;
	fill_pos++;
endtask

task automatic expect_write(int test, word_t pc, reg_addr_t dest, word_t data);
	exp_rec[exp_pos]  = '{pc: pc, dest: dest, data: data};
	exp_test[exp_pos] = test;
	test_last[test]   = exp_pos;
	exp_pos++;
endtask

task automatic build_program();
	int          seed;
	logic [15:0] ia;
	logic [15:0] ib;
	word_t       a;
	word_t       b;
	word_t       hi;
	seed      = 32'h448;
	ia        = 16'($random(seed));
	ib        = 16'($random(seed));
	a         = {{16{ia[15]}}, ia};
	b         = {{16{ib[15]}}, ib};
	hi        = {ib, 16'h0000};
	fill_pos  = 0;
	exp_pos   = 0;
	test_name = '{"alu_chain", "load_store", "branches", "r0_write", "reset_order"};

	// each result feeds the next one straight away.
	add_instr(itype_word(op_addiu, 1, 0, ia));
	add_instr(itype_word(op_addiu, 2, 0, ib));
	add_instr(rtype_word(fn_addu, 3, 1, 2));
	add_instr(rtype_word(fn_subu, 4, 3, 1));
	add_instr(rtype_word(fn_and, 5, 4, 3));
	add_instr(rtype_word(fn_or, 6, 5, 1));
	add_instr(rtype_word(fn_slt, 7, 1, 2));
	add_instr(itype_word(op_lui, 8, 0, ib));
	add_instr(itype_word(op_ori, 9, 8, ia));
	expect_write(0, 32'h00, 1, a);
	expect_write(0, 32'h04, 2, b);
	expect_write(0, 32'h08, 3, a + b);
	expect_write(0, 32'h0c, 4, b);
	expect_write(0, 32'h10, 5, b & (a + b));
	expect_write(0, 32'h14, 6, (b & (a + b)) | a);
	expect_write(0, 32'h18, 7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
	expect_write(0, 32'h1c, 8, hi);
	expect_write(0, 32'h20, 9, hi | {16'h0000, ia});

	// stores land at word addresses 0x48 and 0x4c.
	add_instr(itype_word(op_lui, 10, 0, 16'h1234));
	add_instr(itype_word(op_ori, 10, 10, 16'h5678));
	add_instr(itype_word(op_addiu, 11, 0, 16'h0040));
	add_instr(itype_word(op_sw, 10, 11, 16'h0008));
	add_instr(itype_word(op_lw, 12, 11, 16'h0008));
	add_instr(rtype_word(fn_addu, 13, 12, 11));
	add_instr(itype_word(op_sw, 13, 11, 16'h000c));
	add_instr(itype_word(op_lw, 14, 11, 16'h000c));
	expect_write(1, 32'h24, 10, 32'h1234_0000);
	expect_write(1, 32'h28, 10, 32'h1234_5678);
	expect_write(1, 32'h2c, 11, 32'h0000_0040);
	expect_write(1, 32'h34, 12, 32'h1234_5678);
	expect_write(1, 32'h38, 13, 32'h1234_56b8);
	expect_write(1, 32'h40, 14, 32'h1234_56b8);

	// the words at 0x54, 0x70 and 0x7c are skipped.
	add_instr(itype_word(op_addiu, 15, 0, 16'h0003));
	add_instr(itype_word(op_addiu, 16, 0, 16'h0003));
	add_instr(itype_word(op_beq, 16, 15, 16'h0002));
	add_instr(itype_word(op_addiu, 17, 0, 16'h0001));
	add_instr(itype_word(op_addiu, 17, 0, 16'h0002));
	add_instr(itype_word(op_bne, 16, 15, 16'h0002));
	add_instr(itype_word(op_addiu, 18, 0, 16'h0004));
	add_instr(itype_word(op_addiu, 18, 18, 16'h0005));
	add_instr(itype_word(op_lw, 19, 0, 16'h0048));
	add_instr(itype_word(op_bne, 0, 19, 16'h0002));
	add_instr(itype_word(op_addiu, 20, 0, 16'h0006));
	add_instr(itype_word(op_addiu, 20, 0, 16'h0077));
	add_instr(jump_word(32'h80));
	add_instr(itype_word(op_addiu, 21, 0, 16'h0008));
	add_instr(itype_word(op_addiu, 21, 0, 16'h0099));
	add_instr(itype_word(op_addiu, 21, 21, 16'h0001));
	expect_write(2, 32'h44, 15, 32'd3);
	expect_write(2, 32'h48, 16, 32'd3);
	expect_write(2, 32'h50, 17, 32'd1);
	expect_write(2, 32'h5c, 18, 32'd4);
	expect_write(2, 32'h60, 18, 32'd9);
	expect_write(2, 32'h64, 19, 32'h1234_5678);
	expect_write(2, 32'h6c, 20, 32'd6);
	expect_write(2, 32'h78, 21, 32'd8);
	expect_write(2, 32'h80, 21, 32'd9);

	add_instr(itype_word(op_addiu, 0, 0, 16'h0055));
	add_instr(itype_word(op_addiu, 22, 0, 16'h0007));
	add_instr(rtype_word(fn_or, 23, 0, 22));
	expect_write(3, 32'h88, 22, 32'd7);
	expect_write(3, 32'h8c, 23, 32'd7);

	add_instr(itype_word(op_addiu, 24, 0, 16'h0100));
	add_instr(rtype_word(fn_addu, 25, 24, 24));
	expect_write(4, 32'h90, 24, 32'h100);
	expect_write(4, 32'h94, 25, 32'h200);
endtask

/* verification/mips_tb.sv */
`timescale 1ns/1ps

module mips_tb;
	import mips_pkg::*;

	localparam int period_ns = 40;

	logic    clk;
	logic    rst_n;
	word_t   imem_addr;
	instr_t  imem_data;
	logic    retire_valid;
	retire_t retire;

	`include "tb_program.svh"

	// index of the expected record that matches what is on the retire port.
	int   cur      = 0;
	int   next_rec = 0;
	logic on_port  = 1'b0;
	int   checked  = 0;
	int   errors   = 0;
	int   test_errors [test_count];

	clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mips_core #(
		.DM_WORDS (256)
	) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	function automatic instr_t fetch_word(word_t addr);
		if (addr[31:2] < prog_words) begin
			return prog[addr[31:2]];
		end
		return '0;
	endfunction

	function automatic logic matches_next(retire_t seen);
		if (cur >= exp_count) begin
			return 1'b0;
		end
		return seen == exp_rec[cur];
	endfunction

	task automatic report_mismatch(retire_t seen);
		int t;
		if (cur >= exp_count) begin
			$display("unexpected retire past the end of the program at pc %h", seen.pc);
		end else begin
			t = exp_test[cur];
			test_errors[t]++;
			$display("error %s: expected pc %h r%0d %h, actual pc %h r%0d %h",
				test_name[t], exp_rec[cur].pc, exp_rec[cur].dest, exp_rec[cur].data,
				seen.pc, seen.dest, seen.data);
		end
		errors++;
	endtask

	task automatic report_test(int t);
		if (test_errors[t] == 0) begin
			$display("test %s passed", test_name[t]);
		end else begin
			$display("test %s failed with %0d errors", test_name[t], test_errors[t]);
		end
	endtask

	// instruction memory answers the fetch address between rising edges.
	initial begin
		imem_data = '0;
		forever begin
			@(negedge clk);
			imem_data = fetch_word(imem_addr);
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> matches_next(retire))
		else report_mismatch($sampled(retire));

	assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> retire.dest != '0)
		else begin
			$display("a write to register zero left the core as a retire");
			errors++;
		end

	assert property (@(posedge clk) !rst_n |-> !retire_valid)
		else begin
			$display("a retire appeared while reset was asserted");
			errors++;
		end

	// first fetch after reset comes from address zero.
	assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> imem_addr == '0)
		else begin
			$display("fetch address was not zero at the end of reset");
			errors++;
		end

	// the port holds a record for a whole cycle, so it was checked at the edge before.
	always @(negedge clk) begin
		if (on_port) begin
			checked++;
			if (cur < exp_count && cur == test_last[exp_test[cur]]) begin
				report_test(exp_test[cur]);
			end
		end
		on_port = rst_n && retire_valid;
		if (on_port) begin
			cur = next_rec;
			next_rec++;
		end
	end

	initial begin
		for (int i = 0; i < test_count; i++) begin
			test_errors[i] = 0;
		end
		build_program();
		wait (checked == exp_count);
		// idle cycles with nops in flight, nothing more may retire.
		repeat (8) @(posedge clk);
		@(negedge clk);
		$display("tests %0d, records checked %0d of %0d, errors %0d",
			test_count, checked, exp_count, errors);
		if (errors == 0 && checked == exp_count) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#((prog_words * 3 + 20) * period_ns);
		$display("timeout: the core did not retire all expected writes in time");
		$display("tests %0d, records checked %0d of %0d, errors %0d",
			test_count, checked, exp_count, errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* compile.f */
+incdir+verification
hdl/mips_pkg.sv
hdl/npc_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/pipe_control.sv
hdl/mips_core.sv
verification/clk_gen.sv
verification/mips_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mips_tb -f compile.f -o mips_sim
./obj_dir/mips_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
